/* files.f */
+incdir+testbench
src/dp_core_pkg.sv
src/dp_bus_pkg.sv
src/register_file.sv
src/alu.sv
src/mem_arbiter.sv
src/data_memory.sv
src/data_path.sv
testbench/tb_data_path.sv

/* Bender.yml */
package:
  name: data_path

sources:
  - files:
      - src/dp_core_pkg.sv
      - src/dp_bus_pkg.sv
      - src/register_file.sv
      - src/alu.sv
      - src/mem_arbiter.sv
      - src/data_memory.sv
      - src/data_path.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_data_path.sv

/* testbench/dp_ref_model.svh */
`ifndef dp_ref_model_svh
`define dp_ref_model_svh

logic [31:0] model_regs [32];
logic [31:0] model_mem [dp_bus_pkg::mem_words];

task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < dp_bus_pkg::mem_words; i++) begin
        model_mem[i] = '0;
    end
endtask

function automatic logic addr_in_range(input logic [31:0] addr);
    return addr < dp_bus_pkg::mem_words * 4;
endfunction

function automatic int word_index(input logic [31:0] addr);
    return (addr >> 2) % dp_bus_pkg::mem_words;  // low two bits dropped.
endfunction

function automatic logic [31:0] model_alu(input dp_core_pkg::alu_op_e op,
        input logic [31:0] a, input logic [31:0] b, output logic c);
    logic [32:0] wide;
    c = 1'b0;
    case (op)
        dp_core_pkg::alu_add: begin
            wide = {1'b0, a} + {1'b0, b};
            c = wide[32];
            return wide[31:0];
        end
        dp_core_pkg::alu_sub: begin
            c = (a >= b);  // set when nothing is borrowed.
            return a - b;
        end
        dp_core_pkg::alu_and: return a & b;
        dp_core_pkg::alu_or:  return a | b;
        dp_core_pkg::alu_xor: return a ^ b;
        dp_core_pkg::alu_not: return ~a;
        dp_core_pkg::alu_sll: return a << b[4:0];
        dp_core_pkg::alu_srl: return a >> b[4:0];
        dp_core_pkg::alu_sra: return $signed(a) >>> b[4:0];
        default: return '0;
    endcase
endfunction

// predicts one operation and applies its write-back to the model.
task automatic predict_op(input dp_core_pkg::alu_op_e op, input int s, t, sh,
        input logic [15:0] im, input logic [31:0] pc, input logic rw, mr, mw, asrc, csrc,
        input logic link, wsel, output logic [31:0] res, output logic c, output logic err);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    int dest;
    sext = {{16{im[15]}}, im};
    a = model_regs[s];
    dest = link ? 31 : (wsel ? t : s);
    c = 1'b0;
    err = 1'b0;
    if (mr || mw) begin
        res = a + sext;  // byte address.
        err = !addr_in_range(res);
        if (mw && !err) begin
            model_mem[word_index(res)] = model_regs[t];
        end else if (mr && !err) begin
            res = model_mem[word_index(res)];
            model_regs[dest] = res;  // loads ignore reg_write.
        end
    end else begin
        b = asrc ? (csrc ? {27'b0, sh[4:0]} : sext) : model_regs[t];
        res = model_alu(op, a, b, c);
        if (rw) begin
            model_regs[dest] = link ? pc : res;
        end
    end
endtask

`endif

/* testbench/tb_data_path.sv */
`timescale 1ns/10ps

module tb_data_path;

    localparam int alu_ops = 300;
    localparam int mem_rounds = 20;
    localparam int arb_rounds = 16;
    localparam int total_ops = alu_ops + 3 + mem_rounds * 3 + arb_rounds * 5 + 8 + 7;
    localparam int watchdog_ns = (total_ops * 20 + 10) * 40;

    logic clk;
    logic rst_n;
    logic op_valid;
    logic op_ready;
    logic op_done;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] shamt;
    logic [31:0] npc;
    logic [15:0] imm;
    dp_core_pkg::alu_op_e alu_op;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic alu_src;
    logic const_src;
    logic reg_to_pc;
    logic wr_sel;
    logic [31:0] alu_result;
    logic carry_flag;
    logic sign_flag;
    logic zero_flag;
    logic mem_error;
    logic host_psel;
    logic host_penable;
    logic host_pwrite;
    logic [31:0] host_paddr;
    logic [31:0] host_pwdata;
    logic [31:0] host_prdata;
    logic host_pready;
    logic host_pslverr;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int failing_tests = 0;
    int checks = 0;
    int ops_issued = 0;
    int done_seen = 0;
    int host_issued = 0;
    int host_done = 0;

    `include "dp_ref_model.svh"

    data_path dut0 (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (op_done === 1'b1) begin
            done_seen++;  // every completion pulse.
        end
    end

    always @(posedge clk) begin
        if (host_pready === 1'b1) begin
            host_done++;  // one per completed host transfer.
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("test failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            failing_tests++;
        end
        $display("%s: done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic execute_op(input dp_core_pkg::alu_op_e op, input int s, t, sh,
            input logic [15:0] im, input logic [31:0] pc, input logic rw, mr, mw, asrc,
            input logic csrc, link, wsel);
        logic [31:0] exp_res;
        logic exp_c;
        logic exp_err;
        int cycles;
        predict_op(op, s, t, sh, im, pc, rw, mr, mw, asrc, csrc, link, wsel,
                   exp_res, exp_c, exp_err);
        @(negedge clk);
        alu_op = op;
        rs = s;
        rt = t;
        shamt = sh;
        imm = im;
        npc = pc;
        reg_write = rw;
        mem_read = mr;
        mem_write = mw;
        alu_src = asrc;
        const_src = csrc;
        reg_to_pc = link;
        wr_sel = wsel;
        op_valid = 1'b1;
        while (!op_ready) begin
            @(negedge clk);
        end
        @(negedge clk);  // accepted at the rising edge before.
        op_valid = 1'b0;
        ops_issued++;
        cycles = 1;
        while (!op_done) begin
            @(negedge clk);
            cycles++;
        end
        if (!(mr || mw) && cycles != 1) begin
            $display("%0t: op_done came %0d cycles after acceptance, not 1", $time, cycles);
            test_errors++;
        end
        // grant, memory setup and memory access each take a cycle.
        if ((mr || mw) && cycles < 4) begin
            $display("%0t: op_done came before the memory transfer could end", $time);
            test_errors++;
        end
        if (!(mr && exp_err)) begin
            check_value("alu_result", alu_result, exp_res);
            check_value("sign_flag", sign_flag, exp_res[31]);
            check_value("zero_flag", zero_flag, exp_res == '0);
        end
        check_value("carry_flag", carry_flag, exp_c);
        check_value("mem_error", mem_error, exp_err);
    endtask

    task automatic load_word(input int w);
        execute_op(dp_core_pkg::alu_add, 1, $urandom_range(2, 31), 0, 16'(w * 4), 0,
                   0, 1, 0, 0, 0, 0, 1);
    endtask

    // r1 holds zero, so the immediate is the address.
    task automatic store_load(input int lo, input int hi);
        int w;
        int t;
        t = $urandom_range(2, 31);
        w = $urandom_range(lo, hi);
        execute_op(dp_core_pkg::alu_add, 1, t, 0, 16'(w * 4 + $urandom_range(0, 3)), 0,
                   0, 0, 1, 0, 0, 0, 0);
        t = $urandom_range(2, 31);
        w = $urandom_range(lo, hi);
        execute_op(dp_core_pkg::alu_add, 1, t, 0, 16'(w * 4), 0, 0, 1, 0, 0, 0, 0, 1);
        execute_op(dp_core_pkg::alu_or, t, 0, 0, 16'h0, 0, 0, 0, 0, 1, 0, 0, 0);
    endtask

    task automatic host_transfer(input logic wr, input logic [31:0] addr,
            input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
        host_issued++;
        @(negedge clk);
        host_psel = 1'b1;
        host_penable = 1'b0;
        host_pwrite = wr;
        host_paddr = addr;
        host_pwdata = wdata;
        @(negedge clk);
        host_penable = 1'b1;
        #1;
        while (!host_pready) begin  // held off while the core owns memory.
            @(negedge clk);
            #1;
        end
        rdata = host_prdata;
        err = host_pslverr;
        @(negedge clk);
        host_psel = 1'b0;
        host_penable = 1'b0;
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic err;
        host_transfer(1'b1, addr, data, rdata, err);
        check_value("host_pslverr", err, !addr_in_range(addr));
        if (addr_in_range(addr)) begin
            model_mem[word_index(addr)] = data;
        end
    endtask

    task automatic host_read(input logic [31:0] addr);
        logic [31:0] rdata;
        logic err;
        host_transfer(1'b0, addr, '0, rdata, err);
        check_value("host_pslverr", err, !addr_in_range(addr));
        if (addr_in_range(addr)) begin
            check_value("host_prdata", rdata, model_mem[word_index(addr)]);
        end
    endtask

    initial begin
        int op_code;
        logic [31:0] bits;
        logic [31:0] pc;
        clk = 1'b0;
        rst_n = 1'b0;
        op_valid = 1'b0;
        rs = '0;
        rt = '0;
        shamt = '0;
        npc = '0;
        imm = '0;
        alu_op = dp_core_pkg::alu_add;
        reg_write = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        alu_src = 1'b0;
        const_src = 1'b0;
        reg_to_pc = 1'b0;
        wr_sel = 1'b0;
        host_psel = 1'b0;
        host_penable = 1'b0;
        host_pwrite = 1'b0;
        host_paddr = '0;
        host_pwdata = '0;
        void'($urandom(48));
        clear_model();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_value("op_ready", op_ready, 1'b1);
        check_value("op_done", op_done, 1'b0);
        check_value("host_pready", host_pready, 1'b0);
        check_value("host_pslverr", host_pslverr, 1'b0);
        check_value("alu_result", alu_result, '0);
        check_value("carry_flag", carry_flag, 1'b0);
        check_value("sign_flag", sign_flag, 1'b0);
        check_value("zero_flag", zero_flag, 1'b0);
        check_value("mem_error", mem_error, 1'b0);
        finish_test("reset");

        repeat (alu_ops) begin
            op_code = $urandom_range(0, 8);
            bits = $urandom;
            pc = $urandom;
            // random bits pick sources, wr_sel, write enable, link and operands.
            execute_op(dp_core_pkg::alu_op_e'(op_code), bits[15:11], bits[20:16],
                       bits[25:21], pc[31:16], pc, bits[6:3] != 0, 1'b0, 1'b0,
                       bits[0], bits[1], bits[10:7] == 0, bits[2]);
        end
        finish_test("alu operations");

        pc = $urandom;
        execute_op(dp_core_pkg::alu_add, 0, 0, 0, 16'h0, pc, 1, 0, 0, 1, 0, 1, 0);
        execute_op(dp_core_pkg::alu_or, 31, 0, 0, 16'h0, 0, 0, 0, 0, 1, 0, 0, 0);
        check_value("alu_result", alu_result, pc);
        finish_test("link write");

        execute_op(dp_core_pkg::alu_and, 1, 0, 0, 16'h0, 0, 1, 0, 0, 1, 0, 0, 0);
        repeat (mem_rounds) store_load(0, 31);
        finish_test("core store/load");

        fork
            begin
                for (int i = 0; i < arb_rounds; i++) begin
                    host_write((32 + i) * 4, $urandom);
                end
                for (int i = 0; i < arb_rounds; i++) begin
                    host_read((32 + i) * 4);
                end
            end
            begin
                repeat (arb_rounds) store_load(0, 31);
            end
        join
        repeat (8) load_word(32 + $urandom_range(0, arb_rounds - 1));
        @(posedge clk);
        if (done_seen != ops_issued) begin
            $display("op_done pulsed %0d times for %0d operations", done_seen, ops_issued);
            test_errors++;
        end
        if (host_done != host_issued) begin
            $display("host_pready completed %0d transfers for %0d issued",
                     host_done, host_issued);
            test_errors++;
        end
        finish_test("arbitration");

        host_write(32'h100, $urandom);  // aliases word 0 if not blocked.
        host_read(32'h104);
        execute_op(dp_core_pkg::alu_add, 1, 5, 0, 16'h0100, 0, 0, 0, 1, 0, 0, 0, 0);
        execute_op(dp_core_pkg::alu_add, 1, 6, 0, 16'hfffc, 0, 0, 1, 0, 0, 0, 0, 1);
        host_read(32'h0);
        host_read(32'h4);
        load_word(0);
        finish_test("range error");

        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, failing_tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src/data_path.sv */
`timescale 1ns/10ps

module data_path (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   op_valid,
    output logic                                   op_ready,
    output logic                                   op_done,
    input  logic [dp_core_pkg::reg_addr_width-1:0] rs,
    input  logic [dp_core_pkg::reg_addr_width-1:0] rt,
    input  logic [dp_core_pkg::reg_addr_width-1:0] shamt,
    input  logic [dp_core_pkg::data_width-1:0]     npc,
    input  logic [dp_core_pkg::imm_width-1:0]      imm,
    input  dp_core_pkg::alu_op_e                   alu_op,
    input  logic                                   reg_write,
    input  logic                                   mem_read,
    input  logic                                   mem_write,
    input  logic                                   alu_src,
    input  logic                                   const_src,
    input  logic                                   reg_to_pc,
    input  logic                                   wr_sel,
    output logic [dp_core_pkg::data_width-1:0]     alu_result,
    output logic                                   carry_flag,
    output logic                                   sign_flag,
    output logic                                   zero_flag,
    output logic                                   mem_error,
    input  logic                                   host_psel,
    input  logic                                   host_penable,
    input  logic                                   host_pwrite,
    input  logic [dp_bus_pkg::mem_addr_width-1:0]  host_paddr,
    input  logic [dp_bus_pkg::apb_data_width-1:0]  host_pwdata,
    output logic [dp_bus_pkg::apb_data_width-1:0]  host_prdata,
    output logic                                   host_pready,
    output logic                                   host_pslverr
);

    logic [dp_core_pkg::data_width-1:0]     rd_data_a;
    logic [dp_core_pkg::data_width-1:0]     rd_data_b;
    logic [dp_core_pkg::data_width-1:0]     imm_ext;
    logic [dp_core_pkg::data_width-1:0]     const_val;
    logic [dp_core_pkg::data_width-1:0]     alu_b;
    logic [dp_core_pkg::data_width-1:0]     alu_out;
    logic                                   alu_carry;
    logic                                   alu_sign;
    logic                                   alu_zero;
    dp_core_pkg::alu_op_e                   op_sel;
    logic [dp_core_pkg::reg_addr_width-1:0] dest;
    logic [dp_core_pkg::reg_addr_width-1:0] dest_q;
    logic                                   rf_wr_en;
    logic [dp_core_pkg::reg_addr_width-1:0] rf_wr_addr;
    logic [dp_core_pkg::data_width-1:0]     rf_wr_data;
    logic                                   mem_op;
    logic                                   accept;
    logic                                   alu_accept;
    logic                                   mem_finish;
    logic [dp_core_pkg::data_width-1:0]     mem_report;
    logic                                   load_q;
    dp_bus_pkg::apb_phase_e                 state;
    logic                                   core_pwrite;
    logic [dp_bus_pkg::mem_addr_width-1:0]  core_paddr;
    logic [dp_bus_pkg::apb_data_width-1:0]  core_pwdata;
    logic [dp_bus_pkg::apb_data_width-1:0]  core_prdata;
    logic                                   core_pready;
    logic                                   core_pslverr;
    logic                                   mem_psel;
    logic                                   mem_penable;
    logic                                   mem_pwrite;
    logic [dp_bus_pkg::mem_addr_width-1:0]  mem_paddr;
    logic [dp_bus_pkg::apb_data_width-1:0]  mem_pwdata;
    logic [dp_bus_pkg::apb_data_width-1:0]  mem_prdata;
    logic                                   mem_pready;
    logic                                   mem_pslverr;

    assign imm_ext = {{(dp_core_pkg::data_width - dp_core_pkg::imm_width){imm[15]}}, imm};
    assign const_val = const_src ?
        {{(dp_core_pkg::data_width - dp_core_pkg::reg_addr_width){1'b0}}, shamt} : imm_ext;
    assign mem_op = mem_read | mem_write;
    // memory operations always compute rs + imm.
    assign op_sel = mem_op ? dp_core_pkg::alu_add : alu_op;
    assign alu_b = mem_op ? imm_ext : (alu_src ? const_val : rd_data_b);
    assign dest = reg_to_pc ? dp_core_pkg::link_reg : (wr_sel ? rt : rs);

    assign op_ready = (state == dp_bus_pkg::idle);
    assign accept = op_valid & op_ready;
    assign alu_accept = accept & ~mem_op;
    assign mem_finish = (state == dp_bus_pkg::access) & core_pready;
    assign mem_report = load_q ? core_prdata : core_paddr;  // store reports its address.

    // load data arrives while no new op can be accepted.
    assign rf_wr_en = (alu_accept & reg_write) | (mem_finish & load_q & ~core_pslverr);
    assign rf_wr_addr = mem_finish ? dest_q : dest;
    assign rf_wr_data = mem_finish ? core_prdata : (reg_to_pc ? npc : alu_out);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= dp_bus_pkg::idle;
            op_done <= 1'b0;
            load_q <= 1'b0;
            core_pwrite <= 1'b0;
            alu_result <= '0;
            carry_flag <= 1'b0;
            sign_flag <= 1'b0;
            zero_flag <= 1'b0;
            mem_error <= 1'b0;
        end else begin
            op_done <= alu_accept | mem_finish;
            case (state)
                dp_bus_pkg::idle: begin
                    if (accept && mem_op) begin
                        state <= dp_bus_pkg::setup;
                        load_q <= mem_read;
                        core_pwrite <= ~mem_read;  // read wins if both set.
                    end
                end
                dp_bus_pkg::setup: begin
                    state <= dp_bus_pkg::access;
                end
                dp_bus_pkg::access: begin
                    if (core_pready) begin
                        state <= dp_bus_pkg::idle;
                    end
                end
                default: begin
                    state <= dp_bus_pkg::idle;
                end
            endcase
            if (alu_accept) begin
                alu_result <= alu_out;
                carry_flag <= alu_carry;
                sign_flag <= alu_sign;
                zero_flag <= alu_zero;
                mem_error <= 1'b0;
            end else if (mem_finish) begin
                alu_result <= mem_report;
                carry_flag <= 1'b0;
                sign_flag <= mem_report[dp_core_pkg::data_width-1];
                zero_flag <= (mem_report == '0);
                mem_error <= core_pslverr;
            end
        end
    end

    // transfer payload held from setup to the end of access.
    always_ff @(posedge clk) begin
        if (accept && mem_op) begin
            core_paddr <= alu_out;
            core_pwdata <= rd_data_b;
            dest_q <= dest;
        end
    end

    register_file u_register_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rs),
        .rd_addr_b (rt),
        .wr_addr   (rf_wr_addr),
        .wr_en     (rf_wr_en),
        .wr_data   (rf_wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    alu u_alu (
        .a      (rd_data_a),
        .b      (alu_b),
        .op     (op_sel),
        .result (alu_out),
        .carry  (alu_carry),
        .sign   (alu_sign),
        .zero   (alu_zero)
    );

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_psel    (state != dp_bus_pkg::idle),
        .core_penable (state == dp_bus_pkg::access),
        .core_pwrite  (core_pwrite),
        .core_paddr   (core_paddr),
        .core_pwdata  (core_pwdata),
        .core_prdata  (core_prdata),
        .core_pready  (core_pready),
        .core_pslverr (core_pslverr),
        .host_psel    (host_psel),
        .host_penable (host_penable),
        .host_pwrite  (host_pwrite),
        .host_paddr   (host_paddr),
        .host_pwdata  (host_pwdata),
        .host_prdata  (host_prdata),
        .host_pready  (host_pready),
        .host_pslverr (host_pslverr),
        .mem_psel     (mem_psel),
        .mem_penable  (mem_penable),
        .mem_pwrite   (mem_pwrite),
        .mem_paddr    (mem_paddr),
        .mem_pwdata   (mem_pwdata),
        .mem_prdata   (mem_prdata),
        .mem_pready   (mem_pready),
        .mem_pslverr  (mem_pslverr)
    );

    data_memory u_data_memory (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (mem_psel),
        .penable (mem_penable),
        .pwrite  (mem_pwrite),
        .paddr   (mem_paddr),
        .pwdata  (mem_pwdata),
        .prdata  (mem_prdata),
        .pready  (mem_pready),
        .pslverr (mem_pslverr)
    );

endmodule

/* src/data_memory.sv */
`timescale 1ns/10ps

module data_memory (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [dp_bus_pkg::mem_addr_width-1:0]  paddr,
    input  logic [dp_bus_pkg::apb_data_width-1:0]  pwdata,
    output logic [dp_bus_pkg::apb_data_width-1:0]  prdata,
    output logic                                   pready,
    output logic                                   pslverr
);

    logic [dp_bus_pkg::apb_data_width-1:0]  words [dp_bus_pkg::mem_words];
    logic [dp_bus_pkg::mem_index_width-1:0] index;
    logic                                   in_range;
    logic                                   active;

    assign index = paddr[dp_bus_pkg::mem_index_width+1:2];  // word address.
    assign in_range = (paddr[dp_bus_pkg::mem_addr_width-1:dp_bus_pkg::mem_index_width+2] == '0);
    assign active = psel & penable;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dp_bus_pkg::mem_words; i++) begin
                words[i] <= '0;
            end
        end else if (active && pwrite && in_range) begin
            words[index] <= pwdata;
        end
    end

    // no wait states.
    assign pready = active;
    assign pslverr = active & ~in_range;
    assign prdata = (active && !pwrite && in_range) ? words[index] : '0;

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   core_psel,
    input  logic                                   core_penable,
    input  logic                                   core_pwrite,
    input  logic [dp_bus_pkg::mem_addr_width-1:0]  core_paddr,
    input  logic [dp_bus_pkg::apb_data_width-1:0]  core_pwdata,
    output logic [dp_bus_pkg::apb_data_width-1:0]  core_prdata,
    output logic                                   core_pready,
    output logic                                   core_pslverr,
    input  logic                                   host_psel,
    input  logic                                   host_penable,
    input  logic                                   host_pwrite,
    input  logic [dp_bus_pkg::mem_addr_width-1:0]  host_paddr,
    input  logic [dp_bus_pkg::apb_data_width-1:0]  host_pwdata,
    output logic [dp_bus_pkg::apb_data_width-1:0]  host_prdata,
    output logic                                   host_pready,
    output logic                                   host_pslverr,
    output logic                                   mem_psel,
    output logic                                   mem_penable,
    output logic                                   mem_pwrite,
    output logic [dp_bus_pkg::mem_addr_width-1:0]  mem_paddr,
    output logic [dp_bus_pkg::apb_data_width-1:0]  mem_pwdata,
    input  logic [dp_bus_pkg::apb_data_width-1:0]  mem_prdata,
    input  logic                                   mem_pready,
    input  logic                                   mem_pslverr
);

    dp_bus_pkg::owner_e     owner;
    dp_bus_pkg::apb_phase_e phase;  // memory side phase.
    logic                   last_host;
    logic                   core_own;
    logic                   host_own;

    assign core_own = (owner == dp_bus_pkg::own_core);
    assign host_own = (owner == dp_bus_pkg::own_host);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= dp_bus_pkg::own_none;
            phase <= dp_bus_pkg::idle;
            last_host <= 1'b1;  // core wins the first tie.
        end else begin
            case (phase)
                dp_bus_pkg::idle: begin
                    if (core_psel && (!host_psel || last_host)) begin
                        owner <= dp_bus_pkg::own_core;
                        phase <= dp_bus_pkg::setup;
                        last_host <= 1'b0;
                    end else if (host_psel) begin
                        owner <= dp_bus_pkg::own_host;
                        phase <= dp_bus_pkg::setup;
                        last_host <= 1'b1;
                    end
                end
                dp_bus_pkg::setup: begin
                    phase <= dp_bus_pkg::access;
                end
                dp_bus_pkg::access: begin
                    if (mem_pready) begin  // grant ends with the transfer.
                        owner <= dp_bus_pkg::own_none;
                        phase <= dp_bus_pkg::idle;
                    end
                end
                default: begin
                    owner <= dp_bus_pkg::own_none;
                    phase <= dp_bus_pkg::idle;
                end
            endcase
        end
    end

    // memory sees the owner's transfer one cycle after the grant.
    assign mem_psel = core_own | host_own;
    assign mem_penable = (phase == dp_bus_pkg::access) &&
                         (host_own ? host_penable : core_penable);
    assign mem_pwrite = host_own ? host_pwrite : core_pwrite;
    assign mem_paddr = host_own ? host_paddr : core_paddr;
    assign mem_pwdata = host_own ? host_pwdata : core_pwdata;

    assign core_prdata = core_own ? mem_prdata : '0;
    assign core_pready = core_own & mem_pready;
    assign core_pslverr = core_own & mem_pslverr;
    assign host_prdata = host_own ? mem_prdata : '0;
    assign host_pready = host_own & mem_pready;  // others wait in access.
    assign host_pslverr = host_own & mem_pslverr;

endmodule

/* src/alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic [dp_core_pkg::data_width-1:0] a,
    input  logic [dp_core_pkg::data_width-1:0] b,
    input  dp_core_pkg::alu_op_e               op,
    output logic [dp_core_pkg::data_width-1:0] result,
    output logic                               carry,
    output logic                               sign,
    output logic                               zero
);

    logic [dp_core_pkg::data_width:0] sum;  // one extra bit for carry out.
    logic [4:0]                       amount;

    assign amount = b[4:0];

    always_comb begin
        sum = '0;
        carry = 1'b0;
        case (op)
            dp_core_pkg::alu_add: begin
                sum = {1'b0, a} + {1'b0, b};
                result = sum[dp_core_pkg::data_width-1:0];
                carry = sum[dp_core_pkg::data_width];
            end
            dp_core_pkg::alu_sub: begin
                // top bit of a + ~b + 1 set means no borrow.
                sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
                result = sum[dp_core_pkg::data_width-1:0];
                carry = sum[dp_core_pkg::data_width];
            end
            dp_core_pkg::alu_and: begin
                result = a & b;
            end
            dp_core_pkg::alu_or: begin
                result = a | b;
            end
            dp_core_pkg::alu_xor: begin
                result = a ^ b;
            end
            dp_core_pkg::alu_not: begin
                result = ~a;
            end
            dp_core_pkg::alu_sll: begin
                result = a << amount;
            end
            dp_core_pkg::alu_srl: begin
                result = a >> amount;
            end
            dp_core_pkg::alu_sra: begin
                result = $signed(a) >>> amount;  // keeps the sign bit.
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign sign = result[dp_core_pkg::data_width-1];
    assign zero = (result == '0);

endmodule

/* src/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [dp_core_pkg::reg_addr_width-1:0]  rd_addr_a,
    input  logic [dp_core_pkg::reg_addr_width-1:0]  rd_addr_b,
    input  logic [dp_core_pkg::reg_addr_width-1:0]  wr_addr,
    input  logic                                    wr_en,
    input  logic [dp_core_pkg::data_width-1:0]      wr_data,
    output logic [dp_core_pkg::data_width-1:0]      rd_data_a,
    output logic [dp_core_pkg::data_width-1:0]      rd_data_b
);

    logic [dp_core_pkg::data_width-1:0] regs [dp_core_pkg::reg_count];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dp_core_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;  // r0 is writable too.
        end
    end

    // reads see the old value during a write cycle.
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

/* src/dp_bus_pkg.sv */
package dp_bus_pkg;

    localparam int mem_words = 64;
    localparam int mem_index_width = $clog2(mem_words);
    localparam int mem_addr_width = 32;  // byte address.
    localparam int apb_data_width = 32;

    typedef enum logic [1:0] {
        idle   = 2'd0,
        setup  = 2'd1,
        access = 2'd2
    } apb_phase_e;

    typedef enum logic [1:0] {
        own_none = 2'd0,
        own_core = 2'd1,
        own_host = 2'd2
    } owner_e;

endpackage

/* src/dp_core_pkg.sv */
package dp_core_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 32;
    localparam int imm_width = 16;

    // destination of a link operation.
    localparam logic [reg_addr_width-1:0] link_reg = 5'd31;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_not = 4'd5,  // unary on a.
        alu_sll = 4'd6,
        alu_srl = 4'd7,
        alu_sra = 4'd8
    } alu_op_e;

endpackage
